/* hw/io_pkg.sv */
package io_pkg;

  ////////////////////////////////////////////////////////////
  // widths and sizes

  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int OffWidth = 22;

  localparam int NumHarts = 2;
  localparam int CtxWidth = $clog2(NumHarts);

  // source 0 is reserved and never raised
  localparam int NumSources = 8;
  localparam int SrcIdWidth = 3;

  // clock cycles per mtime tick
  localparam int TimerDiv = 4;
  localparam int PrescWidth = $clog2(TimerDiv);
  localparam logic [PrescWidth-1:0] PrescMax = PrescWidth'(TimerDiv - 1);

  ////////////////////////////////////////////////////////////
  // address map

  localparam logic [AddrWidth-1:0] ClintBase = 32'h1140_0000;
  localparam logic [AddrWidth-1:0] ClintMask = 32'h0000_FFFF;
  localparam logic [AddrWidth-1:0] PlicBase  = 32'h1100_0000;
  localparam logic [AddrWidth-1:0] PlicMask  = 32'h003F_FFFF;

  // clint: msip 4 apart, mtimecmp 8 apart with the high word at +4
  localparam logic [OffWidth-1:0] ClintMsipOff = 22'h00_0000;
  localparam logic [OffWidth-1:0] ClintCmpOff  = 22'h00_4000;
  localparam logic [OffWidth-1:0] ClintTimeOff = 22'h00_BFF8;

  // plic: enables 0x80 apart, claim words 0x1000 apart
  localparam logic [OffWidth-1:0] PlicPendOff  = 22'h00_1000;
  localparam logic [OffWidth-1:0] PlicEnOff    = 22'h00_2000;
  localparam logic [OffWidth-1:0] PlicClaimOff = 22'h20_0004;

  ////////////////////////////////////////////////////////////
  // bus types

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 wr;
    logic [DataWidth-1:0] wdata;
  } io_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } io_rsp_t;

  typedef struct packed {
    logic [OffWidth-1:0]  off;
    logic                 wr;
    logic [DataWidth-1:0] wdata;
  } dev_req_t;

  typedef struct packed {
    logic [17:0] region;
    logic        hart;
    logic        word_sel;
    logic [1:0]  byte_off;
  } clint_off_t;

  typedef struct packed {
    logic [9:0] region;
    logic [4:0] ctx;
    logic [6:0] word;
  } plic_off_t;

  // same offset word, decoded per device
  typedef union packed {
    clint_off_t clint;
    plic_off_t  plic;
  } dev_off_u;

  typedef enum logic [1:0] {
    GW_IDLE    = 2'd0,
    GW_PENDING = 2'd1,
    GW_CLAIMED = 2'd2
  } gw_state_e;

endpackage

/* hw/plic_gateway.sv */
`timescale 1ns/1ps

module plic_gateway (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic [io_pkg::NumSources-1:0] irq_i,
  input  logic                          claim_i,
  input  logic [io_pkg::SrcIdWidth-1:0] claim_id_i,
  input  logic                          complete_i,
  input  logic [io_pkg::SrcIdWidth-1:0] complete_id_i,
  output logic [io_pkg::NumSources-1:0] pending_o
);

  io_pkg::gw_state_e state_q [io_pkg::NumSources];
  io_pkg::gw_state_e state_d [io_pkg::NumSources];

  // one level-triggered gateway per source
  always_comb begin
    for (int i = 0; i < io_pkg::NumSources; i++) begin
      state_d[i] = state_q[i];
      unique case (state_q[i])
        io_pkg::GW_IDLE: begin
          if (irq_i[i]) begin
            state_d[i] = io_pkg::GW_PENDING;
          end
        end
        io_pkg::GW_PENDING: begin
          if (claim_i && claim_id_i == i[io_pkg::SrcIdWidth-1:0]) begin
            state_d[i] = io_pkg::GW_CLAIMED;
          end
        end
        io_pkg::GW_CLAIMED: begin
          // a line still high re-pends from idle
          if (complete_i && complete_id_i == i[io_pkg::SrcIdWidth-1:0]) begin
            state_d[i] = io_pkg::GW_IDLE;
          end
        end
        default: state_d[i] = io_pkg::GW_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < io_pkg::NumSources; i++) begin
      if (reset_i) begin
        state_q[i] <= io_pkg::GW_IDLE;
      end else begin
        state_q[i] <= state_d[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < io_pkg::NumSources; i++) begin
      pending_o[i] = state_q[i] == io_pkg::GW_PENDING;
    end
  end

endmodule

/* hw/plic_regs.sv */
`timescale 1ns/1ps

module plic_regs (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         sel_i,
  input  io_pkg::dev_req_t             dev_req_i,
  input  logic [6:1]                   irq_i,
  output logic [io_pkg::DataWidth-1:0] rdata_o,
  output logic [io_pkg::NumHarts-1:0]  eip_o
);

  io_pkg::dev_off_u                                    off;
  logic                                                pend_hit;
  logic                                                en_hit;
  logic                                                claim_hit;
  logic [io_pkg::CtxWidth-1:0]                         en_ctx;
  logic [io_pkg::CtxWidth-1:0]                         claim_ctx;
  logic [io_pkg::NumSources-1:0]                       src_lines;
  logic [io_pkg::NumSources-1:0]                       pending;
  logic [io_pkg::NumHarts-1:0][io_pkg::NumSources-1:0] enable_q;
  logic [io_pkg::NumHarts-1:0]                         eip_q;
  logic [io_pkg::SrcIdWidth-1:0]                       claim_id;
  logic                                                claim_stb;
  logic                                                complete_stb;

  always_comb begin
    src_lines = '0;
    src_lines[6:1] = irq_i;
  end

  ////////////////////////////////////////////////////////////
  // offset decode

  assign off = dev_req_i.off;
  assign pend_hit = off.plic.region == io_pkg::PlicPendOff[21:12] &&
                    off.plic.ctx == '0 && off.plic.word == '0;
  assign en_hit = off.plic.region == io_pkg::PlicEnOff[21:12] &&
                  off.plic.ctx < io_pkg::NumHarts && off.plic.word == '0;
  // claim words are 0x1000 apart, context in the low region bits
  assign claim_hit = off.plic.region[9:io_pkg::CtxWidth] ==
                     io_pkg::PlicClaimOff[21:12+io_pkg::CtxWidth] &&
                     off.plic.ctx == '0 && off.plic.word == io_pkg::PlicClaimOff[6:0];

  assign en_ctx    = off.plic.ctx[io_pkg::CtxWidth-1:0];
  assign claim_ctx = off.plic.region[io_pkg::CtxWidth-1:0];

  // lowest pending and enabled source wins
  always_comb begin
    claim_id = '0;
    for (int i = io_pkg::NumSources - 1; i > 0; i--) begin
      if (pending[i] && enable_q[claim_ctx][i]) begin
        claim_id = i[io_pkg::SrcIdWidth-1:0];
      end
    end
  end

  assign claim_stb    = sel_i & ~dev_req_i.wr & claim_hit & (claim_id != '0);
  assign complete_stb = sel_i & dev_req_i.wr & claim_hit;

  plic_gateway plic_gateway_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .irq_i         (src_lines),
    .claim_i       (claim_stb),
    .claim_id_i    (claim_id),
    .complete_i    (complete_stb),
    .complete_id_i (dev_req_i.wdata[io_pkg::SrcIdWidth-1:0]),
    .pending_o     (pending)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= '0;
    end else if (sel_i && dev_req_i.wr && en_hit) begin
      enable_q[en_ctx] <= {dev_req_i.wdata[io_pkg::NumSources-1:1], 1'b0};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eip_q <= '0;
    end else begin
      for (int c = 0; c < io_pkg::NumHarts; c++) begin
        eip_q[c] <= |(pending & enable_q[c]);
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (pend_hit) begin
      rdata_o[io_pkg::NumSources-1:0] = pending;
    end else if (en_hit) begin
      rdata_o[io_pkg::NumSources-1:0] = enable_q[en_ctx];
    end else if (claim_hit) begin
      rdata_o[io_pkg::SrcIdWidth-1:0] = claim_id;
    end
  end

  assign eip_o = eip_q;

endmodule

/* hw/mtime_counter.sv */
`timescale 1ns/1ps

module mtime_counter (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         wr_lo_i,
  input  logic                         wr_hi_i,
  input  logic [io_pkg::DataWidth-1:0] wdata_i,
  output logic [63:0]                  mtime_o
);

  logic [io_pkg::PrescWidth-1:0] prescale_q;
  logic                          tick;
  logic [63:0]                   mtime_q;

  assign tick = prescale_q == io_pkg::PrescMax;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prescale_q <= '0;
      mtime_q    <= '0;
    end else if (wr_lo_i || wr_hi_i) begin
      // software load restarts the prescaler
      prescale_q <= '0;
      if (wr_lo_i) begin
        mtime_q[31:0] <= wdata_i;
      end
      if (wr_hi_i) begin
        mtime_q[63:32] <= wdata_i;
      end
    end else begin
      prescale_q <= tick ? '0 : prescale_q + 1'b1;
      if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
    end
  end

  assign mtime_o = mtime_q;

endmodule

/* hw/clint_regs.sv */
`timescale 1ns/1ps

module clint_regs (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         sel_i,
  input  io_pkg::dev_req_t             dev_req_i,
  output logic [io_pkg::DataWidth-1:0] rdata_o,
  output logic [io_pkg::NumHarts-1:0]  msip_o,
  output logic [io_pkg::NumHarts-1:0]  mtip_o
);

  io_pkg::dev_off_u                   off;
  logic                               wr_en;
  logic                               msip_hit;
  logic                               cmp_hit;
  logic                               time_hit;
  logic                               time_wr_lo;
  logic                               time_wr_hi;
  logic [63:0]                        mtime;
  logic [io_pkg::NumHarts-1:0]        msip_q;
  logic [io_pkg::NumHarts-1:0]        mtip_q;
  logic [io_pkg::NumHarts-1:0][63:0]  mtimecmp_q;

  assign off   = dev_req_i.off;
  assign wr_en = sel_i & dev_req_i.wr;

  // msip words are 4 apart, so the hart sits in word_sel there
  assign msip_hit = {off.clint.region, off.clint.hart} == io_pkg::ClintMsipOff[21:3];
  assign cmp_hit  = off.clint.region == io_pkg::ClintCmpOff[21:4];
  assign time_hit = {off.clint.region, off.clint.hart} == io_pkg::ClintTimeOff[21:3];

  assign time_wr_lo = wr_en & time_hit & ~off.clint.word_sel;
  assign time_wr_hi = wr_en & time_hit & off.clint.word_sel;

  mtime_counter mtime_counter_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .wr_lo_i (time_wr_lo),
    .wr_hi_i (time_wr_hi),
    .wdata_i (dev_req_i.wdata),
    .mtime_o (mtime)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      msip_q     <= '0;
      mtimecmp_q <= '1;
    end else if (wr_en) begin
      if (msip_hit) begin
        msip_q[off.clint.word_sel] <= dev_req_i.wdata[0];
      end
      if (cmp_hit && off.clint.word_sel) begin
        mtimecmp_q[off.clint.hart][63:32] <= dev_req_i.wdata;
      end else if (cmp_hit) begin
        mtimecmp_q[off.clint.hart][31:0] <= dev_req_i.wdata;
      end
    end
  end

  // timer compare per hart
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtip_q <= '0;
    end else begin
      for (int h = 0; h < io_pkg::NumHarts; h++) begin
        mtip_q[h] <= mtime >= mtimecmp_q[h];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (msip_hit) begin
      rdata_o[0] = msip_q[off.clint.word_sel];
    end else if (cmp_hit) begin
      rdata_o = off.clint.word_sel ? mtimecmp_q[off.clint.hart][63:32]
                                   : mtimecmp_q[off.clint.hart][31:0];
    end else if (time_hit) begin
      rdata_o = off.clint.word_sel ? mtime[63:32] : mtime[31:0];
    end
  end

  assign msip_o = msip_q;
  assign mtip_o = mtip_q;

endmodule

/* hw/io_switch.sv */
`timescale 1ns/1ps

module io_switch (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_valid_i,
  input  io_pkg::io_req_t              req_i,
  input  logic [io_pkg::DataWidth-1:0] clint_rdata_i,
  input  logic [io_pkg::DataWidth-1:0] plic_rdata_i,
  output logic                         clint_sel_o,
  output logic                         plic_sel_o,
  output io_pkg::dev_req_t             dev_req_o,
  output logic                         rsp_valid_o,
  output io_pkg::io_rsp_t              rsp_o
);

  logic                         clint_hit;
  logic                         plic_hit;
  logic [io_pkg::AddrWidth-1:0] dev_addr;
  logic [io_pkg::DataWidth-1:0] rdata_d;
  logic                         rsp_valid_q;
  io_pkg::io_rsp_t              rsp_q;

  ////////////////////////////////////////////////////////////
  // address decode

  assign clint_hit = (req_i.addr & ~io_pkg::ClintMask) == io_pkg::ClintBase;
  assign plic_hit  = (req_i.addr & ~io_pkg::PlicMask) == io_pkg::PlicBase;

  assign clint_sel_o = req_valid_i & clint_hit;
  assign plic_sel_o  = req_valid_i & plic_hit;

  assign dev_addr = req_i.addr & (clint_hit ? io_pkg::ClintMask : io_pkg::PlicMask);

  always_comb begin
    dev_req_o.off   = dev_addr[io_pkg::OffWidth-1:0];
    dev_req_o.wr    = req_i.wr;
    dev_req_o.wdata = req_i.wdata;
  end

  ////////////////////////////////////////////////////////////
  // response, error sink when no window hits

  always_comb begin
    rdata_d = '0;
    if (!req_i.wr) begin
      if (clint_hit) begin
        rdata_d = clint_rdata_i;
      end else if (plic_hit) begin
        rdata_d = plic_rdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q.rdata <= rdata_d;
      rsp_q.err   <= !(clint_hit || plic_hit);
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

/* hw/io_fabric.sv */
`timescale 1ns/1ps

module io_fabric (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_valid_i,
  input  io_pkg::io_req_t               req_i,
  input  logic [6:1]                    irq_i,
  output logic                          rsp_valid_o,
  output io_pkg::io_rsp_t               rsp_o,
  output logic [io_pkg::NumHarts-1:0]   msip_o,
  output logic [io_pkg::NumHarts-1:0]   mtip_o,
  output logic [io_pkg::NumHarts-1:0]   eip_o
);

  logic                         clint_sel;
  logic                         plic_sel;
  io_pkg::dev_req_t             dev_req;
  logic [io_pkg::DataWidth-1:0] clint_rdata;
  logic [io_pkg::DataWidth-1:0] plic_rdata;

  io_switch io_switch_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .clint_rdata_i (clint_rdata),
    .plic_rdata_i  (plic_rdata),
    .clint_sel_o   (clint_sel),
    .plic_sel_o    (plic_sel),
    .dev_req_o     (dev_req),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o)
  );

  clint_regs clint_regs_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .sel_i     (clint_sel),
    .dev_req_i (dev_req),
    .rdata_o   (clint_rdata),
    .msip_o    (msip_o),
    .mtip_o    (mtip_o)
  );

  // uart 1, sd 2, eth 3, eth dma tx 4, eth dma rx 5, phy 6
  plic_regs plic_regs_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .sel_i     (plic_sel),
    .dev_req_i (dev_req),
    .irq_i     (irq_i),
    .rdata_o   (plic_rdata),
    .eip_o     (eip_o)
  );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // reset held over two rising edges, released on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

/* tests/io_fabric_properties.sv */
`timescale 1ns/1ps

module io_fabric_properties (
  input logic                                                clk_i,
  input logic                                                reset_i,
  input logic                                                req_valid_i,
  input logic                                                rsp_valid_i,
  input logic [io_pkg::NumHarts-1:0]                         eip_i,
  input logic [io_pkg::NumHarts-1:0][io_pkg::NumSources-1:0] enable_i
);

  int unsigned assert_failures = 0;

  ////////////////////////////////////////////////////////////
  // response handshake

  rsp_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i |=> rsp_valid_i)
    else begin
      $error("response missing one cycle after a request");
      assert_failures++;
    end

  rsp_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |-> $past(req_valid_i))
    else begin
      $error("response raised without a request in the cycle before");
      assert_failures++;
    end

  // eip is registered, so it lags the enables by one cycle
  no_eip_without_enable: assert property (@(posedge clk_i) disable iff (reset_i)
    (enable_i == '0) |=> (eip_i == '0))
    else begin
      $error("external interrupt raised while no source is enabled");
      assert_failures++;
    end

endmodule

bind io_fabric io_fabric_properties io_fabric_props (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_valid_i (req_valid_i),
  .rsp_valid_i (rsp_valid_o),
  .eip_i       (eip_o),
  .enable_i    (plic_regs_inst.enable_q)
);

/* tests/io_fabric_tb.sv */
`timescale 1ns/1ps

module io_fabric_tb;

  // op 0 read, 1 write, 2 idle with only the irq lines applied
  typedef struct packed {
    logic [1:0]                   op;
    logic [io_pkg::AddrWidth-1:0] addr;
    logic [io_pkg::DataWidth-1:0] wdata;
    logic [7:0]                   irq;
    logic [io_pkg::DataWidth-1:0] rdata;
    logic                         rdata_dc;
    logic                         err;
    logic [io_pkg::NumHarts-1:0]  msip;
    logic [io_pkg::NumHarts-1:0]  mtip;
    logic [io_pkg::NumHarts-1:0]  eip;
  } vector_t;

  logic                        clk;
  logic                        reset;
  logic                        req_valid;
  io_pkg::io_req_t             req;
  logic [6:1]                  irq;
  logic                        rsp_valid;
  io_pkg::io_rsp_t             rsp;
  logic [io_pkg::NumHarts-1:0] msip;
  logic [io_pkg::NumHarts-1:0] mtip;
  logic [io_pkg::NumHarts-1:0] eip;

  vector_t vectors[$];
  int      error_count = 0;
  int      cycle_count = 0;
  int      cycle_limit = 50;

  tb_clock tb_clock_inst (
    .clk_o   (clk),
    .reset_o (reset)
  );

  io_fabric io_fabric_inst (
    .clk_i       (clk),
    .reset_i     (reset),
    .req_valid_i (req_valid),
    .req_i       (req),
    .irq_i       (irq),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .msip_o      (msip),
    .mtip_o      (mtip),
    .eip_o       (eip)
  );

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic load_vectors();
    int          fd;
    int          count;
    string       line;
    logic [31:0] op_f;
    logic [31:0] addr_f;
    logic [31:0] wdata_f;
    logic [31:0] irq_f;
    logic [31:0] rdata_f;
    logic [31:0] dc_f;
    logic [31:0] err_f;
    logic [31:0] msip_f;
    logic [31:0] mtip_f;
    logic [31:0] eip_f;
    vector_t     v;
    fd = $fopen("tests/io_fabric_vectors.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open tests/io_fabric_vectors.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", op_f, addr_f, wdata_f,
                        irq_f, rdata_f, dc_f, err_f, msip_f, mtip_f, eip_f);
        if (count == 10) begin
          v.op       = op_f[1:0];
          v.addr     = addr_f;
          v.wdata    = wdata_f;
          v.irq      = irq_f[7:0];
          v.rdata    = rdata_f;
          v.rdata_dc = dc_f[0];
          v.err      = err_f[0];
          v.msip     = msip_f[io_pkg::NumHarts-1:0];
          v.mtip     = mtip_f[io_pkg::NumHarts-1:0];
          v.eip      = eip_f[io_pkg::NumHarts-1:0];
          vectors.push_back(v);
        end else begin
          $display("error: malformed vector line: %s", line);
          error_count++;
        end
      end
    end
    $fclose(fd);
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic apply_vector(input vector_t v);
    irq = v.irq[6:1];
    if (v.op != 2'd2) begin
      req_valid = 1'b1;
      req.addr  = v.addr;
      req.wr    = v.op == 2'd1;
      req.wdata = v.wdata;
      @(negedge clk);
      req_valid = 1'b0;
      req       = '0;
      while (!rsp_valid) begin
        @(negedge clk);
      end
      if (!v.rdata_dc && rsp.rdata !== v.rdata) begin
        report_mismatch("rsp_o.rdata", v.rdata, rsp.rdata);
      end
      if (rsp.err !== v.err) begin
        report_mismatch("rsp_o.err", 32'(v.err), 32'(rsp.err));
      end
    end
    repeat (3) @(negedge clk);
    if (msip !== v.msip) begin
      report_mismatch("msip_o", 32'(v.msip), 32'(msip));
    end
    if (mtip !== v.mtip) begin
      report_mismatch("mtip_o", 32'(v.mtip), 32'(mtip));
    end
    if (eip !== v.eip) begin
      report_mismatch("eip_o", 32'(v.eip), 32'(eip));
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the vectors did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    req_valid = 1'b0;
    req       = '0;
    irq       = '0;
    load_vectors();
    cycle_limit = vectors.size() * 8 + 50;
    if (vectors.size() == 0) begin
      $display("error: no vectors were loaded");
      error_count++;
    end
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    foreach (vectors[i]) begin
      apply_vector(vectors[i]);
    end
    $display("errors: %0d check failures, %0d assertion failures", error_count,
             io_fabric_inst.io_fabric_props.assert_failures);
    if (error_count == 0 && io_fabric_inst.io_fabric_props.assert_failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tb.f */
hw/io_pkg.sv
hw/plic_gateway.sv
hw/plic_regs.sv
hw/mtime_counter.sv
hw/clint_regs.sv
hw/io_switch.sv
hw/io_fabric.sv
tests/tb_clock.sv
tests/io_fabric_properties.sv
tests/io_fabric_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the io_fabric testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module io_fabric_tb \
  -f tb.f

# assertion errors are counted by the testbench, so the run must not stop at the first one
./obj_dir/Vio_fabric_tb +verilator+error+limit+1000 > "$LOG" 2>&1 || true

cat "$LOG"

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
else
  exit 1
fi

/* tests/io_fabric_vectors.txt */
# op addr wdata irq rdata rdata_dc err msip mtip eip, all hex
# op 0 read, 1 write, 2 idle; irq bit n drives source n
0 10000000 00000000 00 00000000 0 1 0 0 0
1 20000000 deadbeef 00 00000000 0 1 0 0 0
0 11410000 00000000 00 00000000 0 1 0 0 0
0 11400100 00000000 00 00000000 0 0 0 0 0
0 11003000 00000000 00 00000000 0 0 0 0 0
1 11400000 00000001 00 00000000 0 0 1 0 0
0 11400000 00000000 00 00000001 0 0 1 0 0
0 11400004 00000000 00 00000000 0 0 1 0 0
1 11400000 00000000 00 00000000 0 0 0 0 0
1 11400004 00000001 00 00000000 0 0 2 0 0
1 11400004 00000000 00 00000000 0 0 0 0 0
1 11404000 00000000 00 00000000 0 0 0 0 0
1 11404004 00000000 00 00000000 0 0 0 1 0
0 11404004 00000000 00 00000000 0 0 0 1 0
1 11404004 ffffffff 00 00000000 0 0 0 0 0
1 11404000 ffffffff 00 00000000 0 0 0 0 0
0 11404000 00000000 00 ffffffff 0 0 0 0 0
1 1140bffc 12345678 00 00000000 0 0 0 0 0
1 1140bff8 00000000 00 00000000 0 0 0 0 0
0 1140bffc 00000000 00 12345678 0 0 0 0 0
0 1140bff8 00000000 00 00000000 1 0 0 0 0
2 00000000 00000000 08 00000000 1 0 0 0 0
1 11002000 00000008 08 00000000 0 0 0 0 1
0 11001000 00000000 08 00000008 0 0 0 0 1
0 11002080 00000000 08 00000000 0 0 0 0 1
0 11200004 00000000 08 00000003 0 0 0 0 0
1 11200004 00000003 00 00000000 0 0 0 0 0
1 11002000 00000024 24 00000000 0 0 0 0 1
0 11200004 00000000 24 00000002 0 0 0 0 1
0 11200004 00000000 24 00000005 0 0 0 0 0
0 11200004 00000000 24 00000000 0 0 0 0 0
1 11200004 00000002 24 00000000 0 0 0 0 1
0 11001000 00000000 24 00000004 0 0 0 0 1
0 11201004 00000000 24 00000000 0 0 0 0 1
